//--- caches_if.sv
// Cache to memory word bus where a request and its address are held until a cycle with d_wait low
interface caches_if;
  import cpu_types_pkg::*;

  logic  d_ren;
  logic  d_wen;
  word_t d_addr;
  word_t d_store;
  word_t d_load;
  logic  d_wait;

  modport dcache (
    output d_ren, d_wen, d_addr, d_store,
    input  d_load, d_wait
  );

  modport ram (
    input  d_ren, d_wen, d_addr, d_store,
    output d_load, d_wait
  );

endinterface

//--- cpu_types_pkg.sv
// Word and data address types for a 32-bit CPU with 8 sets of two-word blocks and byte offsets ignored
package cpu_types_pkg;

  parameter int WORD_W = 32;
  parameter int DTAG_W = 26;  // Address bits above index and block offset
  parameter int DIDX_W = 3;   // 8 sets

  typedef logic [WORD_W-1:0] word_t;

  // Field view of a data address
  typedef struct packed {
    logic [DTAG_W-1:0] tag;
    logic [DIDX_W-1:0] idx;
    logic              blkoff;  // Word within the block
    logic [1:0]        bytoff;
  } dcache_fields_t;

  // One address word seen either raw or split into cache fields
  typedef union packed {
    word_t          addr;
    dcache_fields_t f;
  } dcachef_t;

endpackage

//--- data_cache_unit.f
cpu_types_pkg.sv
mem_types_pkg.sv
datapath_cache_if.sv
caches_if.sv
dcache.sv
ram.sv
data_cache_unit.sv
data_cache_unit_assertions.sv
data_cache_unit_tb.sv

//--- data_cache_unit.sv
// Data cache joined to its wait-state RAM where only address bits 9 to 2 reach memory
module data_cache_unit #(
  parameter int LAT = 2
) (
  input  logic                 CLK,
  input  logic                 nRST,
  input  logic                 dmem_ren,
  input  logic                 dmem_wen,
  input  logic                 halt,
  input  cpu_types_pkg::word_t dmem_addr,
  input  cpu_types_pkg::word_t dmem_store,
  output cpu_types_pkg::word_t dmem_load,
  output cpu_types_pkg::word_t hit_count,
  output cpu_types_pkg::word_t miss_count,
  output logic                 dhit,
  output logic                 flushed
);

  datapath_cache_if dcif ();
  caches_if         cif ();

  // Datapath side
  assign dcif.dmem_ren   = dmem_ren;
  assign dcif.dmem_wen   = dmem_wen;
  assign dcif.dmem_addr  = dmem_addr;
  assign dcif.dmem_store = dmem_store;
  assign dcif.halt       = halt;
  assign dmem_load       = dcif.dmem_load;
  assign dhit            = dcif.dhit;
  assign flushed         = dcif.flushed;

  dcache u_dcache (
    .CLK        (CLK),
    .nRST       (nRST),
    .dcif       (dcif),
    .cif        (cif),
    .hit_count  (hit_count),
    .miss_count (miss_count)
  );

  ram #(.LAT(LAT)) u_ram (
    .CLK  (CLK),
    .nRST (nRST),
    .cif  (cif)
  );

endmodule

//--- data_cache_unit_assertions.sv
// Memory bus and flush checks that hold for any LAT and are idle while nRST is low
module data_cache_unit_assertions (
  input logic                 CLK,
  input logic                 nRST,
  input logic                 d_ren,
  input logic                 d_wen,
  input logic                 d_wait,
  input cpu_types_pkg::word_t d_addr,
  input logic                 flushed
);

  a_one_op: assert property (@(posedge CLK) disable iff (!nRST) !(d_ren && d_wen))
    else $error("Read and write requested together");

  // Request held while the RAM is still counting
  a_hold: assert property (@(posedge CLK) disable iff (!nRST)
    d_wait |=> $stable(d_addr) && $stable(d_ren) && $stable(d_wen))
    else $error("Request or address changed while d_wait was high");

  a_flushed_stays: assert property (@(posedge CLK) disable iff (!nRST) flushed |=> flushed)
    else $error("flushed fell before reset");

  a_idle_after_flush: assert property (@(posedge CLK) disable iff (!nRST)
    flushed |-> !(d_ren || d_wen))
    else $error("Memory request after flushed");

endmodule

bind data_cache_unit data_cache_unit_assertions u_assertions (
  .CLK     (CLK),
  .nRST    (nRST),
  .d_ren   (cif.d_ren),
  .d_wen   (cif.d_wen),
  .d_wait  (cif.d_wait),
  .d_addr  (cif.d_addr),
  .flushed (flushed)
);

//--- data_cache_unit_tb.sv
// Runs the unit with LAT 2 and relies on each reset clearing the RAM so unwritten words read 0
module data_cache_unit_tb;
  import cpu_types_pkg::*;

  localparam int NT       = 13;   // Table entries
  localparam int TIMEOUT  = 50;   // Cycles allowed for one access
  localparam int FLUSH_TO = 400;
  localparam int NRAND    = 20;

  logic  CLK = 1'b0;
  logic  nRST, dmem_ren, dmem_wen, halt, dhit, flushed;
  word_t dmem_addr, dmem_store, dmem_load, hit_count, miss_count;

  string t_name [NT];
  logic  t_wr [NT];
  word_t t_addr [NT];
  word_t t_store [NT];
  word_t t_exp [NT];
  logic  t_fast [NT];  // Hit expected in the first cycle

  word_t model [256];  // Last value written to each RAM word
  int    errors, tests, fails, seed;
  logic  abort;

  data_cache_unit #(.LAT(2)) dut (
    .CLK(CLK), .nRST(nRST), .dmem_ren(dmem_ren), .dmem_wen(dmem_wen), .halt(halt),
    .dmem_addr(dmem_addr), .dmem_store(dmem_store), .dmem_load(dmem_load),
    .hit_count(hit_count), .miss_count(miss_count), .dhit(dhit), .flushed(flushed)
  );

  always #5 CLK = ~CLK;

  // Word address built from cache fields so that tags can share a set
  function automatic word_t blk_addr(input int tag, input int set, input logic blk);
    dcachef_t a;
    a.f.tag    = DTAG_W'(tag);
    a.f.idx    = DIDX_W'(set);
    a.f.blkoff = blk;
    a.f.bytoff = 2'b00;
    return a.addr;
  endfunction

  task automatic add_entry(input int n, input string name, input logic wr, input word_t addr,
                           input word_t store, input word_t exp, input logic fast);
    t_name[n]  = name;
    t_wr[n]    = wr;
    t_addr[n]  = addr;
    t_store[n] = store;
    t_exp[n]   = exp;
    t_fast[n]  = fast;
  endtask

  task automatic check(input string name, input word_t exp, input word_t act, inout logic ok);
    if (exp !== act) begin
      $display("[ERROR] %s: expected %h, got %h", name, exp, act);
      errors++;
      ok = 1'b0;
    end
  endtask

  task automatic finish_test(input string name, input logic ok);
    tests++;
    if (!ok) fails++;
    $display("%-12s %s", name, ok ? "ok" : "FAIL");
  endtask

  // Holds one request from a falling edge through the rising edge that ends it with dhit
  task automatic access(input logic wr, input word_t addr, input word_t store,
                        output word_t load, output logic fast);
    int cyc;
    @(negedge CLK);
    dmem_ren   = ~wr;
    dmem_wen   = wr;
    dmem_addr  = addr;
    dmem_store = store;
    cyc        = 0;
    #1;  // Sample between edges
    while (!dhit && cyc < TIMEOUT) begin
      @(posedge CLK);
      #1;
      cyc++;
    end
    fast = (cyc == 0);
    load = dmem_load;
    if (dhit) begin
      @(posedge CLK);  // Access completes on this edge
    end else begin
      $display("Timeout: no dhit for address %h within %0d cycles", addr, TIMEOUT);
      abort = 1'b1;
    end
  endtask

  initial begin
    word_t load, addr, store;
    logic  fast, ok, wr;
    int    exp_miss, cyc, r;
    errors = 0;
    tests  = 0;
    fails  = 0;
    abort  = 1'b0;
    seed   = 32'h5f5c_4067;
    nRST = 1'b0;
    dmem_ren = 1'b0;
    dmem_wen = 1'b0;
    halt = 1'b0;
    dmem_addr = '0;
    dmem_store = '0;
    add_entry(0, "cold_rd", 1'b0, blk_addr(1, 0, 1'b0), 0, 32'h0, 1'b0);
    add_entry(1, "rd_hit", 1'b0, blk_addr(1, 0, 1'b0), 0, 32'h0, 1'b1);
    add_entry(2, "rd_hit_w1", 1'b0, blk_addr(1, 0, 1'b1), 0, 32'h0, 1'b1);
    add_entry(3, "wr_hit", 1'b1, blk_addr(1, 0, 1'b1), 32'hdead_beef, 32'h0, 1'b1);
    add_entry(4, "rd_back", 1'b0, blk_addr(1, 0, 1'b1), 0, 32'hdead_beef, 1'b1);
    add_entry(5, "wr_miss", 1'b1, blk_addr(2, 0, 1'b0), 32'h1234_5678, 32'h0, 1'b0);
    add_entry(6, "rd_alloc", 1'b0, blk_addr(2, 0, 1'b0), 0, 32'h1234_5678, 1'b1);
    add_entry(7, "rd_other", 1'b0, blk_addr(2, 0, 1'b1), 0, 32'h0, 1'b1);
    // Set 1 conflicts
    add_entry(8, "wr_a", 1'b1, blk_addr(1, 1, 1'b0), 32'ha5a5_0001, 32'h0, 1'b0);
    add_entry(9, "rd_b", 1'b0, blk_addr(2, 1, 1'b0), 0, 32'h0, 1'b0);
    add_entry(10, "rd_c_evict", 1'b0, blk_addr(3, 1, 1'b0), 0, 32'h0, 1'b0);  // Evicts dirty A
    add_entry(11, "rd_a_back", 1'b0, blk_addr(1, 1, 1'b0), 0, 32'ha5a5_0001, 1'b0);
    add_entry(12, "rd_a_w1", 1'b0, blk_addr(1, 1, 1'b1), 0, 32'h0, 1'b1);
    repeat (3) @(negedge CLK);
    nRST = 1'b1;

    exp_miss = 0;
    for (int i = 0; i < NT && !abort; i++) begin
      ok = 1'b1;
      access(t_wr[i], t_addr[i], t_store[i], load, fast);
      if (!abort) begin
        if (!t_wr[i]) check(t_name[i], t_exp[i], load, ok);
        check({t_name[i], " hit"}, word_t'(t_fast[i]), word_t'(fast), ok);
        finish_test(t_name[i], ok);
      end
      if (!t_fast[i]) exp_miss++;
    end

    if (!abort) begin
      ok = 1'b1;
      @(negedge CLK);
      check("hit_count", word_t'(NT), hit_count, ok);  // Every access ends with one dhit
      check("miss_count", word_t'(exp_miss), miss_count, ok);
      finish_test("counters", ok);
      dmem_ren = 1'b0;
      dmem_wen = 1'b0;
      halt     = 1'b1;
      cyc      = 0;
      while (!flushed && cyc < FLUSH_TO) begin
        @(negedge CLK);
        cyc++;
      end
      if (!flushed) begin
        $display("Timeout: flushed did not rise within %0d cycles", FLUSH_TO);
        abort = 1'b1;
      end else begin
        ok = 1'b1;
        check("flush hits", word_t'(NT), hit_count, ok);
        check("flush misses", word_t'(exp_miss), miss_count, ok);
        finish_test("flush", ok);
      end
    end

    if (!abort) begin
      // Fresh reset clears cache and RAM for random traffic
      @(negedge CLK);
      nRST = 1'b0;
      halt = 1'b0;
      repeat (3) @(negedge CLK);
      nRST = 1'b1;
      foreach (model[i]) model[i] = '0;
      for (int i = 0; i < NRAND && !abort; i++) begin
        ok    = 1'b1;
        r     = $random(seed);
        addr  = word_t'(r) & 32'h0000_03fc;  // Word aligned, inside the RAM
        r     = $random(seed);
        wr    = r[0];
        store = word_t'($random(seed));
        access(wr, addr, store, load, fast);
        if (!abort) begin
          if (wr) model[addr[9:2]] = store;
          else check($sformatf("rand_%0d", i), model[addr[9:2]], load, ok);
          finish_test($sformatf("rand_%0d", i), ok);
        end
      end
    end

    $display("%0d tests run, %0d failed, %0d errors", tests, fails, errors);
    if (errors == 0 && !abort) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

endmodule

//--- datapath_cache_if.sv
// Datapath to data cache link where requests are held until dhit and halt stays high until reset
interface datapath_cache_if;
  import cpu_types_pkg::*;

  logic  dmem_ren;
  logic  dmem_wen;
  word_t dmem_addr;
  word_t dmem_store;
  word_t dmem_load;
  logic  dhit;     // One-cycle pulse that ends an access
  logic  halt;
  logic  flushed;  // All dirty blocks written back

  modport dcache (
    input  dmem_ren, dmem_wen, dmem_addr, dmem_store, halt,
    output dmem_load, dhit, flushed
  );

  modport datapath (
    output dmem_ren, dmem_wen, dmem_addr, dmem_store, halt,
    input  dmem_load, dhit, flushed
  );

endinterface

//--- dcache.sv
// Two-way write-back data cache with 8 sets of two words that expects requests held until dhit
module dcache (
  input  logic                 CLK,
  input  logic                 nRST,
  datapath_cache_if.dcache     dcif,
  caches_if.dcache             cif,
  output cpu_types_pkg::word_t hit_count,
  output cpu_types_pkg::word_t miss_count
);
  import cpu_types_pkg::*;

  localparam int NSETS = 2 ** DIDX_W;

  typedef enum logic [3:0] {
    IDLE,
    WB0, WB1,      // Write back the victim
    LOAD0, LOAD1,  // Fetch both words on a read miss
    ALLOC, FILL,   // Write miss takes the tag then fetches the other word
    FLUSH, FWB0, FWB1,
    DONE
  } state_t;

  state_t state, nxt_state;
  logic [DIDX_W:0] fcnt, nxt_fcnt;  // Flush position as {way, set}

  logic [DTAG_W-1:0]       tag_q [2][NSETS];
  word_t                   data_q [2][NSETS][2];
  logic [1:0][NSETS-1:0]   valid_q;
  logic [1:0][NSETS-1:0]   dirty_q;
  logic [NSETS-1:0]        lru_q;  // Way to replace next

  dcachef_t          query;
  dcachef_t          mem_addr;
  logic [DIDX_W-1:0] idx;
  logic              rd, wr;
  logic              hit0, hit1, hit, hit_way, victim;
  logic              miss;
  logic              data_we, data_way, data_blk;
  word_t             data_wd;
  logic              tag_we;
  logic              sel_way, sel_blk, sel_own;
  logic [DIDX_W-1:0] sel_set;

  assign query.addr = dcif.dmem_addr;
  assign idx        = query.f.idx;
  assign rd         = dcif.dmem_ren;
  assign wr         = dcif.dmem_wen & ~dcif.dmem_ren;  // Read wins if both are raised

  assign hit0    = valid_q[0][idx] && (tag_q[0][idx] == query.f.tag);
  assign hit1    = valid_q[1][idx] && (tag_q[1][idx] == query.f.tag);
  assign hit     = hit0 | hit1;
  assign hit_way = hit1;
  assign victim  = lru_q[idx];

  assign dcif.dmem_load = data_q[hit_way][idx][query.f.blkoff];

  // Bus address of the selected block word
  always_comb begin
    mem_addr.f.tag    = sel_own ? query.f.tag : tag_q[sel_way][sel_set];
    mem_addr.f.idx    = sel_set;
    mem_addr.f.blkoff = sel_blk;
    mem_addr.f.bytoff = '0;
  end

  assign cif.d_addr  = mem_addr.addr;
  assign cif.d_store = data_q[sel_way][sel_set][sel_blk];

  always_comb begin
    nxt_state    = state;
    nxt_fcnt     = fcnt;
    dcif.dhit    = 1'b0;
    dcif.flushed = 1'b0;
    cif.d_ren    = 1'b0;
    cif.d_wen    = 1'b0;
    sel_way      = victim;
    sel_set      = idx;
    sel_blk      = 1'b0;
    sel_own      = 1'b1;
    data_we      = 1'b0;
    data_way     = victim;
    data_blk     = query.f.blkoff;
    data_wd      = cif.d_load;
    tag_we       = 1'b0;
    miss         = 1'b0;

    case (state)
      IDLE: begin
        if (rd || wr) begin
          if (hit) begin
            dcif.dhit = 1'b1;
            data_we   = wr;  // Store lands in the hit way
            data_way  = hit_way;
            data_wd   = dcif.dmem_store;
          end else begin
            miss = 1'b1;
            if (dirty_q[victim][idx]) begin
              nxt_state = WB0;
            end else begin
              nxt_state = rd ? LOAD0 : ALLOC;
            end
          end
        end else if (dcif.halt) begin
          nxt_state = FLUSH;
        end
      end

      WB0, WB1: begin
        cif.d_wen = 1'b1;
        sel_own   = 1'b0;
        sel_blk   = (state == WB1);
        if (!cif.d_wait) begin
          if (state == WB0) begin
            nxt_state = WB1;
          end else begin
            nxt_state = rd ? LOAD0 : ALLOC;
          end
        end
      end

      LOAD0, LOAD1: begin
        cif.d_ren = 1'b1;
        sel_blk   = (state == LOAD1);
        if (!cif.d_wait) begin
          data_we   = 1'b1;
          data_blk  = sel_blk;
          tag_we    = (state == LOAD1);  // Block becomes valid with its last word
          nxt_state = (state == LOAD0) ? LOAD1 : IDLE;
        end
      end

      ALLOC: begin
        tag_we    = 1'b1;
        nxt_state = FILL;
      end

      FILL: begin
        cif.d_ren = 1'b1;
        sel_blk   = ~query.f.blkoff;  // Only the word not being written
        if (!cif.d_wait) begin
          data_we   = 1'b1;
          data_blk  = sel_blk;
          nxt_state = IDLE;  // Write then hits
        end
      end

      FLUSH: begin
        sel_own = 1'b0;
        sel_way = fcnt[DIDX_W];
        sel_set = fcnt[DIDX_W-1:0];
        if (dirty_q[sel_way][sel_set]) begin
          nxt_state = FWB0;
        end else if (&fcnt) begin
          nxt_state = DONE;
        end else begin
          nxt_fcnt = fcnt + 1'b1;
        end
      end

      FWB0, FWB1: begin
        cif.d_wen = 1'b1;
        sel_own   = 1'b0;
        sel_way   = fcnt[DIDX_W];
        sel_set   = fcnt[DIDX_W-1:0];
        sel_blk   = (state == FWB1);
        if (!cif.d_wait) begin
          if (state == FWB0) begin
            nxt_state = FWB1;
          end else if (&fcnt) begin
            nxt_state = DONE;
          end else begin
            nxt_state = FLUSH;
            nxt_fcnt  = fcnt + 1'b1;
          end
        end
      end

      DONE: dcif.flushed = 1'b1;  // Held until reset

      default: nxt_state = IDLE;
    endcase
  end

  always_ff @(posedge CLK) begin
    if (data_we) data_q[data_way][idx][data_blk] <= data_wd;
    if (tag_we) tag_q[victim][idx] <= query.f.tag;
  end

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      state      <= IDLE;
      fcnt       <= '0;
      valid_q    <= '0;
      dirty_q    <= '0;
      lru_q      <= '0;
      hit_count  <= '0;
      miss_count <= '0;
    end else begin
      state <= nxt_state;
      fcnt  <= nxt_fcnt;
      if (tag_we) begin
        valid_q[victim][idx] <= 1'b1;
        dirty_q[victim][idx] <= 1'b0;
      end
      if (dcif.dhit) begin
        lru_q[idx] <= ~hit_way;  // Other way is now least recent
        if (wr) dirty_q[hit_way][idx] <= 1'b1;
      end
      // Counters freeze once the program has halted
      if (!dcif.halt) begin
        if (dcif.dhit) hit_count <= hit_count + 1'b1;
        if (miss) miss_count <= miss_count + 1'b1;
      end
    end
  end

endmodule

//--- mem_types_pkg.sv
// Memory side constants for a 256-word RAM addressed by word and its access states
package mem_types_pkg;

  parameter int RAM_AW    = 8;            // Word address width
  parameter int RAM_WORDS = 2 ** RAM_AW;

  // Wait counter states of the RAM
  typedef enum logic [1:0] {
    FREE,   // No request pending
    WAIT,   // Counting wait cycles
    READY   // Word completed last cycle
  } ram_state_t;

endpackage

//--- ram.sv
// Word RAM of 256 words that ignores address bits above 9 and reads 0 until written after reset
module ram #(
  parameter int LAT = 2
) (
  input logic   CLK,
  input logic   nRST,
  caches_if.ram cif
);
  import cpu_types_pkg::*;
  import mem_types_pkg::*;

  localparam int CNT_W = $clog2(LAT + 2);

  word_t             mem [RAM_WORDS];
  ram_state_t        state, nxt_state;
  logic [CNT_W-1:0]  cnt, cur_cnt, nxt_cnt;
  word_t             addr_q;  // Address being counted
  logic              req, ready;
  logic [RAM_AW-1:0] waddr;

  assign req   = cif.d_ren | cif.d_wen;
  assign waddr = cif.d_addr[RAM_AW+1:2];

  // A new or moved request counts from zero
  assign cur_cnt = (state == WAIT && cif.d_addr == addr_q) ? cnt : '0;
  assign ready   = req && (cur_cnt == CNT_W'(LAT));

  assign cif.d_wait = req & ~ready;
  assign cif.d_load = mem[waddr];

  always_comb begin
    if (!req) begin
      nxt_state = FREE;
      nxt_cnt   = '0;
    end else if (ready) begin
      nxt_state = READY;  // Next word starts a fresh count
      nxt_cnt   = '0;
    end else begin
      nxt_state = WAIT;
      nxt_cnt   = cur_cnt + 1'b1;
    end
  end

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      state  <= FREE;
      cnt    <= '0;
      addr_q <= '0;
      for (int i = 0; i < RAM_WORDS; i++) begin
        mem[i] <= '0;
      end
    end else begin
      state  <= nxt_state;
      cnt    <= nxt_cnt;
      addr_q <= cif.d_addr;
      if (cif.d_wen && ready) mem[waddr] <= cif.d_store;  // Write in the release cycle
    end
  end

endmodule

//--- run.sh
#!/bin/sh
# Build and run the data cache unit testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module data_cache_unit_tb \
  -f data_cache_unit.f -o sim_data_cache_unit > build.log 2>&1
if [ $? -ne 0 ]; then
  cat build.log
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/sim_data_cache_unit > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -qx "all tests passed" sim.log; then
  exit 0
fi
exit 1
